// ==== logic/msx_pkg.sv ====
package msx_pkg;

   // Kind of CPU bus access in the current clock
   typedef enum logic [2:0] {
      idle      = 3'd0,
      mem_read  = 3'd1,
      mem_write = 3'd2,
      io_read   = 3'd3,
      io_write  = 3'd4,
      fetch     = 3'd5
   } bus_cycle_t;

   // 8255 PPI answers at A8h-ABh
   localparam logic [7:0] PPI_BASE = 8'hA8;

   // PPI register select, address bits 1:0
   localparam logic [1:0] PPI_REG_A    = 2'd0;
   localparam logic [1:0] PPI_REG_B    = 2'd1;
   localparam logic [1:0] PPI_REG_C    = 2'd2;
   localparam logic [1:0] PPI_REG_MODE = 2'd3;

   // Secondary slot register, seen in page 3 of the expanded slot
   localparam logic [15:0] SUBSLOT_ADDR = 16'hFFFF;

   // Power-up mode of the 8255, all ports inputs
   localparam logic [7:0] PPI_MODE_INIT = 8'h9B;

   // Backing memory address is {slot, subslot, page, offset}
   localparam int RAM_ADDR_W = 20;

endpackage

// ==== logic/io_decoder.sv ====
`timescale 1ns/1ns

module io_decoder
   import msx_pkg::*;
(
   input  logic        clock_bus,
   input  logic        reset,
   input  logic [15:0] addr,
   input  logic [7:0]  data_in,
   input  logic        rd,
   input  logic        wr,
   input  logic        mreq,
   input  logic        iorq,
   input  logic        m1,
   output bus_cycle_t  cycle,
   output logic [7:0]  ppi_slot_sel,
   output logic [7:0]  ppi_rdata,
   output logic        ppi_hit,
   output logic        sub_we,
   output logic        sub_re,
   output logic [3:0]  kb_row,
   output logic        cas_motor,
   output logic        key_click
);

   logic [7:0] port_a;
   logic [7:0] port_c;
   logic [7:0] mode_reg;
   logic       map_valid;
   logic       ppi_sel;
   logic       ppi_we;
   logic [1:0] ppi_reg;

   // Interrupt acknowledge (iorq with m1) falls through to idle
   always_comb begin
      if (mreq && rd && m1) begin
         cycle = fetch;
      end else if (mreq && rd) begin
         cycle = mem_read;
      end else if (mreq && wr) begin
         cycle = mem_write;
      end else if (iorq && rd && !m1) begin
         cycle = io_read;
      end else if (iorq && wr && !m1) begin
         cycle = io_write;
      end else begin
         cycle = idle;
      end
   end

   assign ppi_reg = addr[1:0];
   assign ppi_sel = (addr[7:2] == PPI_BASE[7:2]) && (cycle == io_read || cycle == io_write);
   assign ppi_we  = ppi_sel && (cycle == io_write);
   assign ppi_hit = ppi_sel && (cycle == io_read);

   always_ff @(posedge clock_bus) begin
      if (reset) begin
         port_a    <= 8'h00;
         port_c    <= 8'h00;
         mode_reg  <= PPI_MODE_INIT;
         map_valid <= 1'b0;
      end else if (ppi_we) begin
         map_valid <= 1'b1;
         case (ppi_reg)
            PPI_REG_A:    port_a   <= data_in;
            PPI_REG_C:    port_c   <= data_in;
            PPI_REG_MODE: mode_reg <= data_in;
            default:      ;
         endcase
      end
   end

   // Port B has no keyboard behind it here
   always_comb begin
      case (ppi_reg)
         PPI_REG_A: ppi_rdata = port_a;
         PPI_REG_B: ppi_rdata = 8'hFF;
         PPI_REG_C: ppi_rdata = port_c;
         default:   ppi_rdata = 8'hFF;
      endcase
   end

   // Slot map stays at slot 0 until software touches the PPI
   assign ppi_slot_sel = map_valid ? port_a : 8'h00;

   assign sub_we = (cycle == mem_write) && (addr == SUBSLOT_ADDR);
   assign sub_re = (cycle == mem_read || cycle == fetch) && (addr == SUBSLOT_ADDR);

   assign kb_row    = port_c[3:0];
   assign cas_motor = port_c[4];
   assign key_click = port_c[7];

   a_rd_wr_exclusive: assert property (@(posedge clock_bus) disable iff (reset)
      !(rd && wr))
      else $error("rd and wr asserted together");

   a_mreq_iorq_exclusive: assert property (@(posedge clock_bus) disable iff (reset)
      !(mreq && iorq))
      else $error("mreq and iorq asserted together");

endmodule

// ==== logic/slot_expander.sv ====
`timescale 1ns/1ns

module slot_expander
   import msx_pkg::*;
#(
   parameter logic [1:0] SLOT_ID = 2'd0
)
(
   input  logic       clock_bus,
   input  logic       reset,
   input  logic       expander_en,
   input  bus_cycle_t cycle,
   input  logic [7:0] ppi_slot_sel,
   input  logic [7:0] data_in,
   input  logic       sub_we,
   input  logic       sub_re,
   output logic [7:0] sub_sel,
   output logic [7:0] sub_rdata,
   output logic       sub_hit
);

   logic [7:0] sub_reg;
   logic       active;

   // Register is only reachable when this slot sits in page 3
   assign active = expander_en && (ppi_slot_sel[7:6] == SLOT_ID);

   always_ff @(posedge clock_bus) begin
      if (reset) begin
         sub_reg <= 8'h00;
      end else if (active && sub_we) begin
         sub_reg <= data_in;
      end
   end

   // Real expanders return the register complemented
   assign sub_rdata = ~sub_reg;
   assign sub_hit   = active && sub_re;

   // Unexpanded slot behaves as subslot 0 in every page
   assign sub_sel = expander_en ? sub_reg : 8'h00;

   a_hit_on_read: assert property (@(posedge clock_bus) disable iff (reset)
      sub_hit |-> (cycle == mem_read || cycle == fetch))
      else $error("slot %0d expander hit outside a read cycle", SLOT_ID);

endmodule

// ==== logic/slot_router.sv ====
`timescale 1ns/1ns

module slot_router
   import msx_pkg::*;
(
   input  bus_cycle_t              cycle,
   input  logic [15:0]             addr,
   input  logic [7:0]              data_in,
   input  logic [7:0]              ppi_slot_sel,
   input  logic [7:0]              ppi_rdata,
   input  logic                    ppi_hit,
   input  logic [31:0]             sub_sel_all,
   input  logic [31:0]             sub_rdata_all,
   input  logic [3:0]              sub_hit_all,
   input  logic [7:0]              ram_dout,
   output logic [RAM_ADDR_W-1:0]   ram_addr,
   output logic [7:0]              ram_din,
   output logic                    ram_rnw,
   output logic                    ram_ce,
   output logic [7:0]              data_out
);

   logic [1:0] page;
   logic [1:0] slot;
   logic [1:0] subslot;
   logic [7:0] slot_sub_sel;
   logic [7:0] sub_data;
   logic       mem_cycle;
   logic       reading;
   logic       any_sub_hit;

   // Each page has a 2-bit field in both the slot and subslot maps
   assign page         = addr[15:14];
   assign slot         = ppi_slot_sel[2*page +: 2];
   assign slot_sub_sel = sub_sel_all[8*slot +: 8];
   assign subslot      = slot_sub_sel[2*page +: 2];

   assign ram_addr = {slot, subslot, page, addr[13:0]};
   assign ram_din  = data_in;
   assign ram_rnw  = (cycle != mem_write);

   assign mem_cycle   = (cycle == mem_read) || (cycle == mem_write) || (cycle == fetch);
   assign reading     = (cycle == mem_read) || (cycle == io_read) || (cycle == fetch);
   assign any_sub_hit = |sub_hit_all;

   // Expander register reads do not reach RAM
   assign ram_ce = mem_cycle && !any_sub_hit;

   always_comb begin
      sub_data = 8'hFF;
      for (int i = 0; i < 4; i++) begin
         if (sub_hit_all[i]) begin
            sub_data = sub_rdata_all[8*i +: 8];
         end
      end
   end

   always_comb begin
      if (!reading) begin
         data_out = 8'hFF;
      end else if (ppi_hit) begin
         data_out = ppi_rdata;
      end else if (any_sub_hit) begin
         data_out = sub_data;
      end else if (cycle == mem_read || cycle == fetch) begin
         data_out = ram_dout;
      end else begin
         // Unmapped I/O floats high
         data_out = 8'hFF;
      end
   end

   // Only one slot can own page 3, and only FFFFh is claimed
   always_comb begin
      if (any_sub_hit) begin
         assert ($onehot0(sub_hit_all) && addr == SUBSLOT_ADDR)
            else $error("bad expander hit %b at %h", sub_hit_all, addr);
      end
   end

endmodule

// ==== logic/msx_slot_system.sv ====
`timescale 1ns/1ns

module msx_slot_system
   import msx_pkg::*;
(
   input  logic                  clock_bus,
   input  logic                  reset,
   input  logic [15:0]           addr,
   input  logic [7:0]            data_in,
   input  logic                  rd,
   input  logic                  wr,
   input  logic                  mreq,
   input  logic                  iorq,
   input  logic                  m1,
   output logic [7:0]            data_out,
   output logic [RAM_ADDR_W-1:0] ram_addr,
   output logic [7:0]            ram_din,
   output logic                  ram_rnw,
   output logic                  ram_ce,
   input  logic [7:0]            ram_dout,
   input  logic [3:0]            expander_en,
   output logic [3:0]            kb_row,
   output logic                  cas_motor,
   output logic                  key_click
);

   bus_cycle_t  cycle;
   logic [7:0]  ppi_slot_sel;
   logic [7:0]  ppi_rdata;
   logic        ppi_hit;
   logic        sub_we;
   logic        sub_re;
   logic [31:0] sub_sel_all;
   logic [31:0] sub_rdata_all;
   logic [3:0]  sub_hit_all;

   io_decoder u_io_decoder (
      .clock_bus    (clock_bus),
      .reset        (reset),
      .addr         (addr),
      .data_in      (data_in),
      .rd           (rd),
      .wr           (wr),
      .mreq         (mreq),
      .iorq         (iorq),
      .m1           (m1),
      .cycle        (cycle),
      .ppi_slot_sel (ppi_slot_sel),
      .ppi_rdata    (ppi_rdata),
      .ppi_hit      (ppi_hit),
      .sub_we       (sub_we),
      .sub_re       (sub_re),
      .kb_row       (kb_row),
      .cas_motor    (cas_motor),
      .key_click    (key_click)
   );

   // One expander per primary slot
   for (genvar i = 0; i < 4; i++) begin : g_expander
      slot_expander #(
         .SLOT_ID (2'(i))
      ) u_slot_expander (
         .clock_bus    (clock_bus),
         .reset        (reset),
         .expander_en  (expander_en[i]),
         .cycle        (cycle),
         .ppi_slot_sel (ppi_slot_sel),
         .data_in      (data_in),
         .sub_we       (sub_we),
         .sub_re       (sub_re),
         .sub_sel      (sub_sel_all[8*i +: 8]),
         .sub_rdata    (sub_rdata_all[8*i +: 8]),
         .sub_hit      (sub_hit_all[i])
      );
   end

   slot_router u_slot_router (
      .cycle         (cycle),
      .addr          (addr),
      .data_in       (data_in),
      .ppi_slot_sel  (ppi_slot_sel),
      .ppi_rdata     (ppi_rdata),
      .ppi_hit       (ppi_hit),
      .sub_sel_all   (sub_sel_all),
      .sub_rdata_all (sub_rdata_all),
      .sub_hit_all   (sub_hit_all),
      .ram_dout      (ram_dout),
      .ram_addr      (ram_addr),
      .ram_din       (ram_din),
      .ram_rnw       (ram_rnw),
      .ram_ce        (ram_ce),
      .data_out      (data_out)
   );

endmodule

// ==== test/tb_msx_slot_system.sv ====
`timescale 1ns/1ns

module tb_msx_slot_system
   import msx_pkg::*;
();

   localparam int N_RESET_READS = 32;
   localparam int N_PPI = 100;
   localparam int N_SUB = 100;
   localparam int N_MEM = 2000;
   localparam int N_IO = 50;
   localparam int PLANNED_CYCLES = 5 + N_RESET_READS + 7 * N_PPI + 8 * N_SUB + N_MEM
                                 + 4 * (N_MEM / 64 + 1) + 3 * N_IO;
   localparam int TIMEOUT_CYCLES = 4 * PLANNED_CYCLES;

   logic clock_bus = 1'b0;
   logic reset;
   logic [15:0] addr;
   logic [7:0] data_in, data_out, ram_din, ram_dout;
   logic rd, wr, mreq, iorq, m1;
   logic [RAM_ADDR_W-1:0] ram_addr;
   logic ram_rnw, ram_ce;
   logic [3:0] expander_en, kb_row;
   logic cas_motor, key_click;

   // Reference model state
   logic [7:0] m_port_a, m_port_c;
   logic [7:0] m_sub [4];
   logic [3:0] m_en;
   bit m_map_valid;
   logic [7:0] ram_mem [0:(1 << RAM_ADDR_W) - 1];
   int checks = 0;
   int errors = 0;
   int cycle_count = 0;

   msx_slot_system uut (.*);

   always #5 clock_bus = ~clock_bus;

   // Backing RAM, read combinationally
   assign ram_dout = ram_mem[ram_addr];
   always @(posedge clock_bus) begin
      if (ram_ce && !ram_rnw) ram_mem[ram_addr] <= ram_din;
   end

   always @(posedge clock_bus) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Test failed");
         $finish;
      end
   end

   function automatic logic [7:0] fill_pattern(input logic [RAM_ADDR_W-1:0] a);
      return a[7:0] ^ a[15:8] ^ {a[19:16], a[19:16]} ^ 8'h5A;
   endfunction

   function automatic logic [7:0] model_slot_sel();
      return m_map_valid ? m_port_a : 8'h00;
   endfunction

   // {slot, subslot, page, offset} from the model's maps
   function automatic logic [RAM_ADDR_W-1:0] expected_addr(input logic [15:0] a);
      logic [1:0] page, slot, subslot;
      logic [7:0] ssel;
      page = a[15:14];
      slot = 2'(model_slot_sel() >> (2 * page));
      ssel = m_en[slot] ? m_sub[slot] : 8'h00;
      subslot = 2'(ssel >> (2 * page));
      return {slot, subslot, page, a[13:0]};
   endfunction

   task automatic check(input string name, input logic [31:0] actual,
                        input logic [31:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAIL %s: got %h, expected %h", name, actual, expected);
      end
   endtask

   task automatic drive(input logic mreq_v, input logic iorq_v, input logic rd_v,
                        input logic wr_v, input logic m1_v, input logic [15:0] a,
                        input logic [7:0] d);
      @(negedge clock_bus);
      mreq = mreq_v;
      iorq = iorq_v;
      rd = rd_v;
      wr = wr_v;
      m1 = m1_v;
      addr = a;
      data_in = d;
      #1;
   endtask

   task automatic set_enables(input logic [3:0] en);
      @(negedge clock_bus);
      expander_en = en;
      m_en = en;
   endtask

   task automatic mem_access(input bit write, input bit fetch_cyc, input logic [15:0] a,
                             input logic [7:0] d);
      logic [RAM_ADDR_W-1:0] exp_addr;
      logic [7:0] sel, exp_data;
      logic [1:0] top_slot;
      bit claimed, hit;
      exp_addr = expected_addr(a);
      sel = model_slot_sel();
      top_slot = sel[7:6];
      claimed = (a == SUBSLOT_ADDR) && m_en[top_slot];
      hit = claimed && !write;
      drive(1'b1, 1'b0, !write, write, fetch_cyc && !write, a, d);
      check("ram_ce", 32'(ram_ce), 32'(!hit));
      if (!hit) begin
         check("ram_addr", 32'(ram_addr), 32'(exp_addr));
         check("ram_rnw", 32'(ram_rnw), 32'(!write));
      end
      if (write) begin
         check("ram_din", 32'(ram_din), 32'(d));
         check("data_out", 32'(data_out), 32'h0000_00FF);
         if (claimed) m_sub[top_slot] = d;
      end else begin
         exp_data = hit ? ~m_sub[top_slot] : ram_mem[exp_addr];
         check("data_out", 32'(data_out), 32'(exp_data));
      end
   endtask

   task automatic check_port_c_outputs();
      check("kb_row", 32'(kb_row), 32'(m_port_c[3:0]));
      check("cas_motor", 32'(cas_motor), 32'(m_port_c[4]));
      check("key_click", 32'(key_click), 32'(m_port_c[7]));
   endtask

   task automatic io_write(input logic [7:0] port, input logic [7:0] d);
      drive(1'b0, 1'b1, 1'b0, 1'b1, 1'b0, {8'($urandom), port}, d);
      check("data_out", 32'(data_out), 32'h0000_00FF);
      check("ram_ce", 32'(ram_ce), 32'h0);
      if (port[7:2] == PPI_BASE[7:2]) begin
         m_map_valid = 1'b1;
         if (port[1:0] == 2'd0) m_port_a = d;
         if (port[1:0] == 2'd2) m_port_c = d;
      end
   endtask

   task automatic io_read(input logic [7:0] port);
      logic [7:0] exp_data;
      exp_data = 8'hFF;
      if (port[7:2] == PPI_BASE[7:2] && port[1:0] == 2'd0) exp_data = m_port_a;
      if (port[7:2] == PPI_BASE[7:2] && port[1:0] == 2'd2) exp_data = m_port_c;
      drive(1'b0, 1'b1, 1'b1, 1'b0, 1'b0, {8'($urandom), port}, 8'($urandom));
      check("data_out", 32'(data_out), 32'(exp_data));
      check("ram_ce", 32'(ram_ce), 32'h0);
      check_port_c_outputs();
   endtask

   initial begin
      logic [7:0] port;
      int op;
      void'($urandom(32'hc48a_96a4));
      {addr, data_in, rd, wr, mreq, iorq, m1} = '0;
      expander_en = 4'h0;
      reset = 1'b1;
      m_port_a = 8'h00;
      m_port_c = 8'h00;
      m_map_valid = 1'b0;
      m_en = 4'h0;
      for (int i = 0; i < 4; i++) m_sub[i] = 8'h00;
      for (int i = 0; i < (1 << RAM_ADDR_W); i++) begin
         ram_mem[i[RAM_ADDR_W-1:0]] = fill_pattern(i[RAM_ADDR_W-1:0]);
      end
      repeat (5) @(posedge clock_bus);
      @(negedge clock_bus);
      reset = 1'b0;

      // Slot map stays at slot 0, subslot 0 until the PPI is written
      set_enables(4'($urandom));
      for (int i = 0; i < N_RESET_READS; i++) begin
         mem_access(1'b0, 1'b0, 16'($urandom), 8'h00);
         check("ram_addr[19:16]", 32'(ram_addr[19:16]), 32'h0);
         check_port_c_outputs();
      end

      for (int i = 0; i < N_PPI; i++) begin
         io_write(8'hA8, 8'($urandom));
         io_write(8'hAA, 8'($urandom));
         io_write(8'hAB, 8'($urandom));
         io_read(8'hA8);
         io_read(8'hAA);
         io_read(8'hA9);
         io_read(8'hAB);
      end

      // Expander register at FFFFh under random maps and enables
      for (int i = 0; i < N_SUB; i++) begin
         set_enables(4'($urandom));
         io_write(8'hA8, 8'($urandom));
         mem_access(1'b1, 1'b0, SUBSLOT_ADDR, 8'($urandom));
         mem_access(1'b0, 1'b0, SUBSLOT_ADDR, 8'h00);
         mem_access(1'b0, 1'b1, SUBSLOT_ADDR, 8'h00);
         mem_access(1'b0, 1'b0, 16'($urandom), 8'h00);
      end

      for (int i = 0; i < N_MEM; i++) begin
         if (i % 64 == 0) begin
            set_enables(4'($urandom));
            io_write(8'hA8, 8'($urandom));
            mem_access(1'b1, 1'b0, SUBSLOT_ADDR, 8'($urandom));
         end
         op = int'($urandom_range(0, 3));
         mem_access(op == 0, op == 1, 16'($urandom), 8'($urandom));
      end

      for (int i = 0; i < N_IO; i++) begin
         port = 8'($urandom);
         if (port[7:2] == PPI_BASE[7:2]) port = port ^ 8'h40;
         io_read(port);
         drive(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 16'($urandom), 8'($urandom));
         check("data_out", 32'(data_out), 32'h0000_00FF);
         check("ram_ce", 32'(ram_ce), 32'h0);
         drive(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 16'($urandom), 8'($urandom));
         check("data_out", 32'(data_out), 32'h0000_00FF);
         check("ram_ce", 32'(ram_ce), 32'h0);
      end

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== msx_slot.f ====
logic/msx_pkg.sv
logic/io_decoder.sv
logic/slot_expander.sv
logic/slot_router.sv
logic/msx_slot_system.sv
test/tb_msx_slot_system.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tb_msx_slot_system -f msx_slot.f -o sim_msx_slot

status=0
output=$(./obj_dir/sim_msx_slot 2>&1) || status=$?
echo "$output"

if [ "$status" -eq 0 ] && grep -qx "Test completed successfully" <<< "$output"; then
   exit 0
fi
echo "Simulation did not report a pass"
exit 1
